// File: hw/rv_dec_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_dec_macros.svh"

// rv32im decode into one registered record
module rv_dec_core #(
  parameter bit RV32M = 1'b1
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire logic                    instr_valid_i,
  output logic                         instr_ready_o,
  input  wire logic [`RV_DEC_XLEN-1:0] instr_i,
  output logic                         res_valid_o,
  input  wire logic                    res_ready_i,
  output rv_dec_pkg::dec_result_t      res_o
);

  rv_dec_pkg::opcode_e     opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [`RV_DEC_XLEN-1:0] imm_i;
  logic [`RV_DEC_XLEN-1:0] imm_s;
  logic [`RV_DEC_XLEN-1:0] imm_u;
  rv_dec_pkg::dec_result_t dec_d;   // combinational decode
  rv_dec_pkg::dec_result_t res_q;
  logic                    valid_q;
  logic                    accept;

  assign opcode = rv_dec_pkg::opcode_e'(instr_i[`RV_DEC_OPCODE_W-1:0]);
  assign funct3 = instr_i[`RV_DEC_FUNCT3_LSB +: 3];
  assign funct7 = instr_i[`RV_DEC_FUNCT7_LSB +: 7];

  // sign extension from bit 31
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'b0};

  //////////////////////////////
  // decode
  //////////////////////////////

  always_comb begin
    dec_d          = '0;
    dec_d.alu_op   = rv_dec_pkg::ALU_ADD;
    dec_d.op_a_sel = rv_dec_pkg::OP_A_REG_A;
    dec_d.op_b_sel = rv_dec_pkg::OP_B_REG_B;
    dec_d.imm      = imm_i;                // don't care for reg-reg
    dec_d.rs1      = instr_i[`RV_DEC_RS1_LSB +: `RV_DEC_REG_AW];
    dec_d.rs2      = instr_i[`RV_DEC_RS2_LSB +: `RV_DEC_REG_AW];
    dec_d.rd       = instr_i[`RV_DEC_RD_LSB +: `RV_DEC_REG_AW];
    dec_d.md_op     = rv_dec_pkg::MD_OP_MULL;
    dec_d.data_type = rv_dec_pkg::DT_WORD;

    case (opcode)
      rv_dec_pkg::OPCODE_LOAD: begin
        dec_d.op_b_sel      = rv_dec_pkg::OP_B_IMM; // base + imm_i
        dec_d.rf_we         = 1'b1;
        dec_d.data_req      = 1'b1;
        dec_d.data_sign_ext = !funct3[2];            // lbu/lhu zero extend
        case (funct3[1:0])
          2'b00:   dec_d.data_type = rv_dec_pkg::DT_BYTE;
          2'b01:   dec_d.data_type = rv_dec_pkg::DT_HALF;
          default: dec_d.data_type = rv_dec_pkg::DT_WORD;
        endcase
        if (funct3 == 3'b011 || funct3 == 3'b111) begin
          dec_d.illegal = 1'b1; // ld is rv64, 111 undefined
        end
      end

      rv_dec_pkg::OPCODE_STORE: begin
        dec_d.op_b_sel = rv_dec_pkg::OP_B_IMM;
        dec_d.imm      = imm_s;
        dec_d.data_req = 1'b1;
        dec_d.data_we  = 1'b1;
        case (funct3[1:0])
          2'b00:   dec_d.data_type = rv_dec_pkg::DT_BYTE;
          2'b01:   dec_d.data_type = rv_dec_pkg::DT_HALF;
          default: dec_d.data_type = rv_dec_pkg::DT_WORD;
        endcase
        dec_d.illegal = funct3[2] || (funct3[1:0] == 2'b11);
      end

      rv_dec_pkg::OPCODE_LUI, rv_dec_pkg::OPCODE_AUIPC: begin
        // lui is 0 + imm_u, auipc is pc + imm_u
        dec_d.op_a_sel = (opcode == rv_dec_pkg::OPCODE_LUI) ?
                         rv_dec_pkg::OP_A_ZERO : rv_dec_pkg::OP_A_CURRPC;
        dec_d.op_b_sel = rv_dec_pkg::OP_B_IMM;
        dec_d.imm      = imm_u;
        dec_d.rf_we    = 1'b1;
      end

      rv_dec_pkg::OPCODE_OPIMM: begin
        dec_d.op_b_sel = rv_dec_pkg::OP_B_IMM;
        dec_d.rf_we    = 1'b1;
        case (funct3)
          3'b000: dec_d.alu_op = rv_dec_pkg::ALU_ADD;
          3'b010: dec_d.alu_op = rv_dec_pkg::ALU_SLT;
          3'b011: dec_d.alu_op = rv_dec_pkg::ALU_SLTU;
          3'b100: dec_d.alu_op = rv_dec_pkg::ALU_XOR;
          3'b110: dec_d.alu_op = rv_dec_pkg::ALU_OR;
          3'b111: dec_d.alu_op = rv_dec_pkg::ALU_AND;
          3'b001: begin
            dec_d.alu_op  = rv_dec_pkg::ALU_SLL;
            dec_d.illegal = (funct7 != 7'b000_0000); // shamt[5] or junk
          end
          default: begin // 101, srli/srai
            dec_d.alu_op  = funct7[5] ? rv_dec_pkg::ALU_SRA : rv_dec_pkg::ALU_SRL;
            dec_d.illegal = (funct7 != 7'b000_0000) && (funct7 != 7'b010_0000);
          end
        endcase
      end

      rv_dec_pkg::OPCODE_OP: begin
        dec_d.rf_we = 1'b1;
        if (instr_i[31]) begin
          dec_d.illegal = 1'b1;
        end else if (funct7 == 7'b000_0001) begin // rv32m group
          dec_d.illegal = !RV32M;
          dec_d.mult_en = RV32M && !funct3[2];
          dec_d.div_en  = RV32M && funct3[2];
          case (funct3)
            3'b000:         dec_d.md_op = rv_dec_pkg::MD_OP_MULL;
            3'b100, 3'b101: dec_d.md_op = rv_dec_pkg::MD_OP_DIV;
            3'b110, 3'b111: dec_d.md_op = rv_dec_pkg::MD_OP_REM;
            default:        dec_d.md_op = rv_dec_pkg::MD_OP_MULH;
          endcase
          case (funct3)
            3'b001, 3'b100, 3'b110: dec_d.md_signed_mode = 2'b11; // mulh div rem
            3'b010:                 dec_d.md_signed_mode = 2'b01; // mulhsu
            default:                dec_d.md_signed_mode = 2'b00;
          endcase
        end else begin
          case ({funct7[5:0], funct3})
            {6'b00_0000, 3'b000}: dec_d.alu_op = rv_dec_pkg::ALU_ADD;
            {6'b10_0000, 3'b000}: dec_d.alu_op = rv_dec_pkg::ALU_SUB;
            {6'b00_0000, 3'b010}: dec_d.alu_op = rv_dec_pkg::ALU_SLT;
            {6'b00_0000, 3'b011}: dec_d.alu_op = rv_dec_pkg::ALU_SLTU;
            {6'b00_0000, 3'b100}: dec_d.alu_op = rv_dec_pkg::ALU_XOR;
            {6'b00_0000, 3'b110}: dec_d.alu_op = rv_dec_pkg::ALU_OR;
            {6'b00_0000, 3'b111}: dec_d.alu_op = rv_dec_pkg::ALU_AND;
            {6'b00_0000, 3'b001}: dec_d.alu_op = rv_dec_pkg::ALU_SLL;
            {6'b00_0000, 3'b101}: dec_d.alu_op = rv_dec_pkg::ALU_SRL;
            {6'b10_0000, 3'b101}: dec_d.alu_op = rv_dec_pkg::ALU_SRA;
            default:              dec_d.illegal = 1'b1;
          endcase
        end
      end

      default: dec_d.illegal = 1'b1; // branch, jal, system, fence etc
    endcase

    // illegal word must not reach rf, lsu or md unit
    if (dec_d.illegal) begin
      dec_d.rf_we    = 1'b0;
      dec_d.data_req = 1'b0;
      dec_d.data_we  = 1'b0;
      dec_d.mult_en  = 1'b0;
      dec_d.div_en   = 1'b0;
    end
  end

  //////////////////////////////
  // result stage
  //////////////////////////////

  assign instr_ready_o = !valid_q || res_ready_i; // empty or draining
  assign accept        = instr_valid_i && instr_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (res_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      res_q <= dec_d;
    end
  end

  assign res_valid_o = valid_q;
  assign res_o       = res_q;

  a_illegal_quiet : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (res_valid_o && res_o.illegal) |->
      !(res_o.rf_we || res_o.data_req || res_o.data_we || res_o.mult_en || res_o.div_en));

endmodule

`default_nettype wire

// File: hw/rv_dec_macros.svh
`ifndef RV_DEC_MACROS_SVH
`define RV_DEC_MACROS_SVH

//////////////////////////////
// widths
//////////////////////////////

`define RV_DEC_XLEN 32    // instruction and data word
`define RV_DEC_REG_AW 5   // x0..x31
`define RV_DEC_OPCODE_W 7

//////////////////////////////
// instruction field lsbs
//////////////////////////////

`define RV_DEC_RS1_LSB 15
`define RV_DEC_RS2_LSB 20
`define RV_DEC_RD_LSB 7

// funct3 is 3 bits, funct7 is 7 bits
`define RV_DEC_FUNCT3_LSB 12
`define RV_DEC_FUNCT7_LSB 25

`endif

// File: hw/rv_dec_out_buf.sv
`timescale 1ns/1ns
`default_nettype none

// single-entry registered stream buffer for any payload
module rv_dec_out_buf #(
  parameter type payload_t = logic [31:0]
) (
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  input  wire payload_t in_data_i,
  output logic          out_valid_o,
  input  wire logic     out_ready_i,
  output payload_t      out_data_o
);

  logic     full_q;
  payload_t data_q;  // meaningful only while full_q
  logic     take;

  // pass-through of ready keeps one word per cycle
  assign in_ready_o = !full_q || out_ready_i;
  assign take       = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;   // drained with nothing new
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  // stalled output holds valid and payload
  a_hold_on_stall : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)));

endmodule

`default_nettype wire

// File: hw/rv_dec_pkg.sv
`default_nettype none

`include "rv_dec_macros.svh"

package rv_dec_pkg;

  // the only major opcodes still decoded
  typedef enum logic [`RV_DEC_OPCODE_W-1:0] {
    OPCODE_LOAD  = 7'h03,
    OPCODE_OPIMM = 7'h13,
    OPCODE_AUIPC = 7'h17,
    OPCODE_STORE = 7'h23,
    OPCODE_OP    = 7'h33,
    OPCODE_LUI   = 7'h37
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic [1:0] {MD_OP_MULL, MD_OP_MULH, MD_OP_DIV, MD_OP_REM} md_op_e;

  // lsu access size
  typedef enum logic [1:0] {
    DT_WORD = 2'd0,
    DT_HALF = 2'd1,
    DT_BYTE = 2'd2
  } data_type_e;

  // one decoded instruction of 68 bits
  typedef struct packed {
    alu_op_e                   alu_op;
    op_a_sel_e                 op_a_sel;
    op_b_sel_e                 op_b_sel;
    logic [`RV_DEC_XLEN-1:0]   imm;          // already selected and extended
    logic [`RV_DEC_REG_AW-1:0] rs1;
    logic [`RV_DEC_REG_AW-1:0] rs2;
    logic [`RV_DEC_REG_AW-1:0] rd;
    logic                      rf_we;
    logic                      mult_en;
    logic                      div_en;
    md_op_e                    md_op;
    logic [1:0]                md_signed_mode; // {rs2 signed, rs1 signed}
    logic                      data_req;
    logic                      data_we;
    data_type_e                data_type;
    logic                      data_sign_ext;
    logic                      illegal;
  } dec_result_t;

  // wishbone classic master to slave
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`RV_DEC_XLEN-1:0] dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic                    ack;
    logic [`RV_DEC_XLEN-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: hw/rv_dec_top.sv
`timescale 1ns/1ns
`default_nettype none

// wishbone in, decoded records out
module rv_dec_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire rv_dec_pkg::wb_req_t     wb_req_i,
  output rv_dec_pkg::wb_rsp_t          wb_rsp_o,
  output logic                         dec_valid_o,
  input  wire logic                    dec_ready_i,
  output rv_dec_pkg::dec_result_t      dec_o
);

  logic                    instr_valid;
  logic                    instr_ready;
  logic [31:0]             instr;
  logic                    res_valid;  // core stage to buffer
  logic                    res_ready;
  rv_dec_pkg::dec_result_t res;

  rv_dec_wb_slave u_wb_slave (
    .clk_i, .rst_n_i, .wb_req_i, .wb_rsp_o,
    .instr_valid_o(instr_valid), .instr_ready_i(instr_ready), .instr_o(instr)
  );

  rv_dec_core #(.RV32M(1'b1)) u_core (
    .clk_i, .rst_n_i,
    .instr_valid_i(instr_valid), .instr_ready_o(instr_ready), .instr_i(instr),
    .res_valid_o(res_valid), .res_ready_i(res_ready), .res_o(res)
  );

  rv_dec_out_buf #(.payload_t(rv_dec_pkg::dec_result_t)) u_out_buf (
    .clk_i, .rst_n_i,
    .in_valid_i(res_valid), .in_ready_o(res_ready), .in_data_i(res),
    .out_valid_o(dec_valid_o), .out_ready_i(dec_ready_i), .out_data_o(dec_o)
  );

endmodule

`default_nettype wire

// File: hw/rv_dec_wb_slave.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_dec_macros.svh"

// one-word instruction slot behind a wishbone classic target
module rv_dec_wb_slave (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire rv_dec_pkg::wb_req_t     wb_req_i,
  output rv_dec_pkg::wb_rsp_t          wb_rsp_o,
  output logic                         instr_valid_o,
  input  wire logic                    instr_ready_i,
  output logic [`RV_DEC_XLEN-1:0]      instr_o
);

  logic                    ack_q;    // registered one-pulse ack
  logic                    slot_q;   // slot holds an unsent word
  logic [`RV_DEC_XLEN-1:0] instr_q;  // last written word
  logic                    req_live; // cycle open and not yet acked
  logic                    wr_take;
  logic                    rd_take;

  assign req_live = wb_req_i.cyc && wb_req_i.stb && !ack_q;
  // a full slot that is not draining stalls the bus
  assign wr_take  = req_live && wb_req_i.we && (!slot_q || instr_ready_i);
  assign rd_take  = req_live && !wb_req_i.we; // reads never wait

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q  <= 1'b0;
      slot_q <= 1'b0;
    end else begin
      ack_q <= wr_take || rd_take;
      if (wr_take) begin
        slot_q <= 1'b1;         // refill wins over drain
      end else if (instr_ready_i) begin
        slot_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      instr_q <= wb_req_i.dat;
    end
  end

  assign wb_rsp_o.ack  = ack_q;
  assign wb_rsp_o.dat  = instr_q; // last written word
  assign instr_valid_o = slot_q;
  assign instr_o       = instr_q;

  // ack only answers a strobe seen one cycle earlier
  a_ack_after_stb : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_q |-> $past(wb_req_i.cyc && wb_req_i.stb));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the rv_dec testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ns --top-module tb_rv_dec \
  -f rv_dec.f -o sim_tb_rv_dec
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_rv_dec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: rv_dec.f
+incdir+hw
hw/rv_dec_pkg.sv
hw/rv_dec_wb_slave.sv
hw/rv_dec_core.sv
hw/rv_dec_out_buf.sv
hw/rv_dec_top.sv
testbench/tb_rv_dec.sv

// File: testbench/tb_rv_dec.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_dec_macros.svh"

module tb_rv_dec;

  localparam int N_INSTR = 300;
  localparam int TIMEOUT = N_INSTR * 20 + 100; // cycles for worst case per word plus margin

  logic                    clk;
  logic                    rst_n;
  rv_dec_pkg::wb_req_t     wb_req;
  rv_dec_pkg::wb_rsp_t     wb_rsp;
  logic                    dec_valid;
  logic                    dec_ready;
  rv_dec_pkg::dec_result_t dec;

  rv_dec_pkg::dec_result_t exp_q[$];        // expected records with oldest first
  rv_dec_pkg::dec_result_t exp_head = '0;
  int                      exp_cnt  = 0;
  int                      n_wr     = 0;
  int                      n_out    = 0;
  int                      val_errs = 0;
  int                      oth_errs = 0;
  int                      cycles   = 0;
  logic                    push_pend = 1'b0;
  logic                    pop_pend  = 1'b0;
  logic [`RV_DEC_XLEN-1:0] push_word = '0;
  logic [`RV_DEC_XLEN-1:0] last_wr   = '0;   // for read-back
  logic                    stall_en  = 1'b0; // random dec_ready on
  logic                    done      = 1'b0;
  logic                    fire;
  logic                    legal;
  logic                    rd_ack;

  rv_dec_top u_dut (
    .clk_i(clk), .rst_n_i(rst_n), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
    .dec_valid_o(dec_valid), .dec_ready_i(dec_ready), .dec_o(dec)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // reference decode
  //////////////////////////////

  function automatic rv_dec_pkg::alu_op_e base_alu(input logic [2:0] f3);
    case (f3)
      3'd0:    base_alu = rv_dec_pkg::ALU_ADD;
      3'd1:    base_alu = rv_dec_pkg::ALU_SLL;
      3'd2:    base_alu = rv_dec_pkg::ALU_SLT;
      3'd3:    base_alu = rv_dec_pkg::ALU_SLTU;
      3'd4:    base_alu = rv_dec_pkg::ALU_XOR;
      3'd5:    base_alu = rv_dec_pkg::ALU_SRL;
      3'd6:    base_alu = rv_dec_pkg::ALU_OR;
      default: base_alu = rv_dec_pkg::ALU_AND;
    endcase
  endfunction

  function automatic rv_dec_pkg::dec_result_t ref_decode(input logic [31:0] w);
    rv_dec_pkg::dec_result_t r;
    logic [2:0]              f3;
    logic [6:0]              f7;
    f3          = w[14:12];
    f7          = w[31:25];
    r           = '0;
    r.rs1       = w[19:15];
    r.rs2       = w[24:20];
    r.rd        = w[11:7];
    r.imm       = {{20{w[31]}}, w[31:20]};  // i type unless changed
    r.rf_we     = 1'b1;
    r.op_b_sel  = rv_dec_pkg::OP_B_IMM;     // every class but OP
    // size only matters for load/store
    r.data_type = (f3[1:0] == 2'b00) ? rv_dec_pkg::DT_BYTE :
                  (f3[0] ? rv_dec_pkg::DT_HALF : rv_dec_pkg::DT_WORD);
    case (w[6:0])
      7'h03: begin
        r.data_req      = 1'b1;
        r.data_sign_ext = !f3[2];
        r.illegal       = (f3[1:0] == 2'b11); // funct3 3 and 7
      end
      7'h23: begin
        r.rf_we    = 1'b0;
        r.imm      = {{20{w[31]}}, w[31:25], w[11:7]};
        r.data_req = 1'b1;
        r.data_we  = 1'b1;
        r.illegal  = f3[2] || (f3[1:0] == 2'b11);
      end
      7'h37, 7'h17: begin
        r.imm      = {w[31:12], 12'h000};
        r.op_a_sel = (w[6:0] == 7'h37) ? rv_dec_pkg::OP_A_ZERO : rv_dec_pkg::OP_A_CURRPC;
      end
      7'h13: begin
        r.alu_op = base_alu(f3);
        if (f3 == 3'd1) begin
          r.illegal = (f7 != 7'h00);
        end else if (f3 == 3'd5 && f7 == 7'h20) begin
          r.alu_op = rv_dec_pkg::ALU_SRA;
        end else if (f3 == 3'd5) begin
          r.illegal = (f7 != 7'h00);
        end
      end
      7'h33: begin
        r.op_b_sel = rv_dec_pkg::OP_B_REG_B;
        r.alu_op   = base_alu(f3);
        if (f7 == 7'h01) begin                  // mul/div group
          r.alu_op  = rv_dec_pkg::ALU_ADD;      // alu idle for md ops
          r.mult_en = !f3[2];
          r.div_en  = f3[2];
          if (f3[2])
            r.md_op = f3[1] ? rv_dec_pkg::MD_OP_REM : rv_dec_pkg::MD_OP_DIV;
          else
            r.md_op = (f3[1:0] == 2'b00) ? rv_dec_pkg::MD_OP_MULL : rv_dec_pkg::MD_OP_MULH;
          case (f3)
            3'd1, 3'd4, 3'd6: r.md_signed_mode = 2'b11;
            3'd2:             r.md_signed_mode = 2'b01; // mulhsu signs rs1 only
            default:          r.md_signed_mode = 2'b00;
          endcase
        end else if (f7 == 7'h20 && f3 == 3'd0) begin
          r.alu_op = rv_dec_pkg::ALU_SUB;
        end else if (f7 == 7'h20 && f3 == 3'd5) begin
          r.alu_op = rv_dec_pkg::ALU_SRA;
        end else if (f7 != 7'h00) begin
          r.illegal = 1'b1;                     // also catches bit 31
        end
      end
      default: r.illegal = 1'b1;
    endcase
    if (r.illegal) begin
      r.rf_we    = 1'b0;
      r.data_req = 1'b0;
      r.data_we  = 1'b0;
      r.mult_en  = 1'b0;
      r.div_en   = 1'b0;
    end
    return r;
  endfunction

  // field groups for compare
  function automatic logic [5:0] enables(input rv_dec_pkg::dec_result_t r);
    return {r.rf_we, r.data_req, r.data_we, r.mult_en, r.div_en, r.illegal};
  endfunction

  function automatic logic [7:0] ops(input rv_dec_pkg::dec_result_t r);
    return {r.alu_op, r.op_a_sel, r.op_b_sel};
  endfunction

  function automatic logic [14:0] regs(input rv_dec_pkg::dec_result_t r);
    return {r.rs1, r.rs2, r.rd};
  endfunction

  function automatic logic [3:0] md(input rv_dec_pkg::dec_result_t r);
    return {r.md_op, r.md_signed_mode};
  endfunction

  function automatic logic [2:0] mem(input rv_dec_pkg::dec_result_t r);
    return {r.data_type, r.data_sign_ext};
  endfunction

  //////////////////////////////
  // stimulus
  //////////////////////////////

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = $urandom();
    case ($urandom() % 8)
      0, 1: begin
        case ($urandom() % 6)
          0, 1:    w[31:25] = 7'h00;
          2:       w[31:25] = 7'h20;
          3, 4:    w[31:25] = 7'h01; // rv32m
          default: ;                 // random funct7 is mostly illegal
        endcase
        w[6:0] = 7'h33;
      end
      2: begin
        if ($urandom() % 2 == 1) begin
          w[31:25] = ($urandom() % 2 == 1) ? 7'h20 : 7'h00; // legal shift funct7
        end
        w[6:0] = 7'h13;
      end
      3: w[6:0] = ($urandom() % 2 == 1) ? 7'h37 : 7'h17;
      4: w[6:0] = 7'h03;
      5: w[6:0] = 7'h23;
      6: begin
        case ($urandom() % 4)
          0:       w[6:0] = 7'h63; // branch
          1:       w[6:0] = 7'h6f; // jal
          2:       w[6:0] = 7'h73; // system
          default: w[6:0] = 7'h0f; // misc-mem
        endcase
      end
      default: ;                   // whole word random
    endcase
    return w;
  endfunction

  // classic cycle held through the ack cycle
  task automatic bus_cycle(input logic we, input logic [`RV_DEC_XLEN-1:0] dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.dat = dat;
    @(negedge clk);
    while (!wb_rsp.ack) begin
      @(negedge clk);
    end
    if (we) begin
      last_wr = dat;
    end
    @(posedge clk);
    #1;
    wb_req = '0;
  endtask

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    val_errs++;
    $display("Error: %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
  endtask

  task automatic flow_error(input string msg);
    oth_errs++;
    $display("%s at %0t", msg, $time);
  endtask

  task automatic print_counts();
    $display("%0d words written, %0d records out, %0d value errors, %0d other errors",
             n_wr, n_out, val_errs, oth_errs);
  endtask

  always @(posedge clk) begin
    #1;
    dec_ready <= stall_en ? ($urandom() % 4 != 0) : 1'b1;
  end

  //////////////////////////////
  // scoreboard
  //////////////////////////////

  assign fire   = dec_valid && dec_ready;
  assign legal  = fire && !exp_head.illegal;
  assign rd_ack = wb_rsp.ack && !wb_req.we;

  // seen at negedge and acted on at the next posedge
  always @(negedge clk) begin
    push_pend <= rst_n && wb_rsp.ack && wb_req.we;
    push_word <= wb_req.dat;
    pop_pend  <= rst_n && fire;
  end

  always @(posedge clk) begin
    if (pop_pend) begin
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      n_out++;
    end
    if (push_pend) begin
      exp_q.push_back(ref_decode(push_word));
      n_wr++;
    end
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
  end

  a_expected : assert property (@(negedge clk) disable iff (!rst_n) fire |-> exp_cnt != 0)
    else flow_error("a record came out with no written word pending");
  a_enables : assert property (@(negedge clk) disable iff (!rst_n)
    fire |-> enables(dec) == enables(exp_head))
    else value_error("dec.{rf_we,data_req,data_we,mult_en,div_en,illegal}",
                     32'(enables(exp_head)), 32'(enables(dec)));
  a_regs : assert property (@(negedge clk) disable iff (!rst_n) fire |-> regs(dec) == regs(exp_head))
    else value_error("dec.{rs1,rs2,rd}", 32'(regs(exp_head)), 32'(regs(dec)));
  a_ops : assert property (@(negedge clk) disable iff (!rst_n) legal |-> ops(dec) == ops(exp_head))
    else value_error("dec.{alu_op,op_a_sel,op_b_sel}", 32'(ops(exp_head)), 32'(ops(dec)));
  a_imm : assert property (@(negedge clk) disable iff (!rst_n)
    legal && exp_head.op_b_sel == rv_dec_pkg::OP_B_IMM |-> dec.imm == exp_head.imm)
    else value_error("dec.imm", exp_head.imm, dec.imm);
  a_md : assert property (@(negedge clk) disable iff (!rst_n)
    legal && (exp_head.mult_en || exp_head.div_en) |-> md(dec) == md(exp_head))
    else value_error("dec.{md_op,md_signed_mode}", 32'(md(exp_head)), 32'(md(dec)));
  a_mem : assert property (@(negedge clk) disable iff (!rst_n)
    legal && exp_head.data_req |-> mem(dec) == mem(exp_head))
    else value_error("dec.{data_type,data_sign_ext}", 32'(mem(exp_head)), 32'(mem(dec)));
  a_read : assert property (@(negedge clk) disable iff (!rst_n) rd_ack |-> wb_rsp.dat == last_wr)
    else value_error("wb_rsp.dat", last_wr, wb_rsp.dat);
  a_count : assert property (@(negedge clk) done |-> n_out == n_wr)
    else flow_error("number of records out differs from number of words written");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("timeout after %0d cycles, %0d records still pending", cycles, exp_cnt);
      print_counts();
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    int i;
    clk       = 1'b0;
    rst_n     = 1'b0;
    wb_req    = '0;
    dec_ready = 1'b0;
    void'($urandom(62880));
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (i = 0; i < 8; i++) begin           // the eight rv32m words
      bus_cycle(1'b1, {7'h01, 5'd3, 5'd2, i[2:0], 5'd1, 7'h33});
    end
    bus_cycle(1'b1, {20'h12345, 5'd1, 7'h37}); // lui
    bus_cycle(1'b1, {20'hfedcb, 5'd2, 7'h17}); // auipc
    bus_cycle(1'b1, {7'h60, 5'd5, 5'd4, 3'd0, 5'd6, 7'h33}); // sub with bit 31 set
    stall_en = 1'b1;
    for (i = 0; i < N_INSTR - 11; i++) begin
      bus_cycle(1'b1, rand_word());
      if (i % 16 == 15) begin
        bus_cycle(1'b0, '0);                // read back last word
      end
    end
    stall_en = 1'b0;
    while (exp_cnt != 0 || dec_valid) begin
      @(negedge clk);
    end
    done = 1'b1;
    @(negedge clk);
    @(posedge clk);
    print_counts();
    if (val_errs + oth_errs == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
